//--- source/hello_reg_bank.sv
`timescale 1ns/10ps

module hello_reg_bank
(
  input  logic                             clk_main_a0,
  input  logic                             rst_main_n_sync,
  // Write strobe from the write channel
  input  logic                             reg_wr,
  input  logic [ocl_bus_pkg::addr_w-1:0]   reg_wr_addr,
  input  logic [ocl_bus_pkg::data_w-1:0]   reg_wr_data,
  // Register views
  output logic [ocl_bus_pkg::data_w-1:0]   hello_swapped,
  output logic [hello_reg_pkg::vled_w-1:0] vled_value
);

  logic [ocl_bus_pkg::data_w-1:0] hello_q;

  // ----------------------------------------------------------------------
  // Hello-world register
  // ----------------------------------------------------------------------
  // Writes elsewhere in the map are dropped here
  always_ff @(posedge clk_main_a0)
    if (!rst_main_n_sync)
      hello_q <= hello_reg_pkg::hello_reset_val;
    else if (reg_wr && (reg_wr_addr == hello_reg_pkg::hello_world_addr))
      hello_q <= reg_wr_data;

  // Byte order reversed on the way out
  assign hello_swapped = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};

  // ----------------------------------------------------------------------
  // Virtual LED shadow
  // ----------------------------------------------------------------------
  // Trails the low half by one cycle
  always_ff @(posedge clk_main_a0)
    if (!rst_main_n_sync)
      vled_value <= '0;
    else
      vled_value <= hello_q[hello_reg_pkg::vled_w-1:0];

endmodule

//--- source/hello_reg_pkg.sv
package hello_reg_pkg;

  // ----------------------------------------------------------------------
  // Register map
  // ----------------------------------------------------------------------
  // Hello-world register reads back byte-swapped
  localparam logic [31:0] hello_world_addr = 32'h0000_0500;

  // Virtual LED register is a read only shadow
  localparam logic [31:0] vled_addr = 32'h0000_0504;

  // ----------------------------------------------------------------------
  // Widths and reset values
  // ----------------------------------------------------------------------
  // LED and DIP lanes
  localparam int vled_w = 16;

  // Hello-world contents out of reset
  localparam logic [31:0] hello_reset_val = 32'h0000_0000;

endpackage

//--- source/hello_regs_top.sv
`timescale 1ns/10ps

module hello_regs_top
(
  input  logic                             clk_main_a0,
  input  logic                             rst_main_n_sync,
  // Write address
  input  logic                             awvalid,
  input  logic [ocl_bus_pkg::addr_w-1:0]   awaddr,
  output logic                             awready,
  // Write data
  input  logic                             wvalid,
  input  logic [ocl_bus_pkg::data_w-1:0]   wdata,
  output logic                             wready,
  // Write response
  output logic                             bvalid,
  output logic [1:0]                       bresp,
  input  logic                             bready,
  // Read address
  input  logic                             arvalid,
  input  logic [ocl_bus_pkg::addr_w-1:0]   araddr,
  output logic                             arready,
  // Read data
  output logic                             rvalid,
  output logic [ocl_bus_pkg::data_w-1:0]   rdata,
  output logic [1:0]                       rresp,
  input  logic                             rready,
  // Status pins
  input  logic [hello_reg_pkg::vled_w-1:0] status_vdip,
  output logic [hello_reg_pkg::vled_w-1:0] status_vled
);

  // ----------------------------------------------------------------------
  // Internal wires
  // ----------------------------------------------------------------------
  // Write channel to bank
  logic                             reg_wr;
  logic [ocl_bus_pkg::addr_w-1:0]   reg_wr_addr;
  logic [ocl_bus_pkg::data_w-1:0]   reg_wr_data;

  // Bank to readers
  logic [ocl_bus_pkg::data_w-1:0]   hello_swapped;
  logic [hello_reg_pkg::vled_w-1:0] vled_value;

  // ----------------------------------------------------------------------
  // Bus side
  // ----------------------------------------------------------------------
  ocl_write_channel wr_chan_i
  (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .reg_wr          (reg_wr),
    .reg_wr_addr     (reg_wr_addr),
    .reg_wr_data     (reg_wr_data)
  );

  ocl_read_channel rd_chan_i
  (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .hello_swapped   (hello_swapped),
    .vled_value      (vled_value)
  );

  // ----------------------------------------------------------------------
  // Registers and LED status
  // ----------------------------------------------------------------------
  hello_reg_bank reg_bank_i
  (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_wr          (reg_wr),
    .reg_wr_addr     (reg_wr_addr),
    .reg_wr_data     (reg_wr_data),
    .hello_swapped   (hello_swapped),
    .vled_value      (vled_value)
  );

  vled_status vled_status_i
  (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .status_vdip     (status_vdip),
    .vled_value      (vled_value),
    .status_vled     (status_vled)
  );

endmodule

//--- source/ocl_bus_pkg.sv
package ocl_bus_pkg;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------
  localparam int addr_w = 32;
  localparam int data_w = 32;

  // Only OKAY is ever returned
  localparam logic [1:0] resp_okay = 2'b00;

  // ----------------------------------------------------------------------
  // Channel state machines
  // ----------------------------------------------------------------------
  // Write side
  typedef enum logic [1:0]
  {
    wr_idle,
    wr_data,
    wr_resp
  } wr_state_t;

  // Read side
  typedef enum logic [1:0]
  {
    rd_idle,
    rd_decode,
    rd_resp
  } rd_state_t;

endpackage

//--- source/ocl_read_channel.sv
`timescale 1ns/10ps

module ocl_read_channel
(
  input  logic                            clk_main_a0,
  input  logic                            rst_main_n_sync,
  // Read address
  input  logic                            arvalid,
  input  logic [ocl_bus_pkg::addr_w-1:0]  araddr,
  output logic                            arready,
  // Read data and response
  output logic                            rvalid,
  output logic [ocl_bus_pkg::data_w-1:0]  rdata,
  output logic [1:0]                      rresp,
  input  logic                            rready,
  // Register views from the bank
  input  logic [ocl_bus_pkg::data_w-1:0]  hello_swapped,
  input  logic [hello_reg_pkg::vled_w-1:0] vled_value
);

  ocl_bus_pkg::rd_state_t rd_state;
  ocl_bus_pkg::rd_state_t rd_state_nxt;

  logic [ocl_bus_pkg::addr_w-1:0] araddr_q;
  logic [ocl_bus_pkg::data_w-1:0] rd_value;

  // ----------------------------------------------------------------------
  // Handshake decode
  // ----------------------------------------------------------------------
  assign arready = (rd_state == ocl_bus_pkg::rd_idle);
  assign rvalid  = (rd_state == ocl_bus_pkg::rd_resp);

  // Only OKAY is returned
  assign rresp   = ocl_bus_pkg::resp_okay;

  // Address decode on the captured address
  always_comb
  begin
    if (araddr_q == hello_reg_pkg::hello_world_addr)
      rd_value = hello_swapped;
    else if (araddr_q == hello_reg_pkg::vled_addr)
      rd_value = {{(ocl_bus_pkg::data_w - hello_reg_pkg::vled_w){1'b0}}, vled_value};
    else
      // Unmapped reads give zero
      rd_value = '0;
  end

  // ----------------------------------------------------------------------
  // State machine
  // ----------------------------------------------------------------------
  always_comb
  begin
    rd_state_nxt = rd_state;
    case (rd_state)
      ocl_bus_pkg::rd_idle:
        if (arvalid)
          rd_state_nxt = ocl_bus_pkg::rd_decode;
      ocl_bus_pkg::rd_decode:
        rd_state_nxt = ocl_bus_pkg::rd_resp;
      ocl_bus_pkg::rd_resp:
        if (rready)
          rd_state_nxt = ocl_bus_pkg::rd_idle;
      default:
        rd_state_nxt = ocl_bus_pkg::rd_idle;
    endcase
  end

  always_ff @(posedge clk_main_a0)
    if (!rst_main_n_sync)
      rd_state <= ocl_bus_pkg::rd_idle;
    else
      rd_state <= rd_state_nxt;

  // Capture on the AR transfer
  always_ff @(posedge clk_main_a0)
    if (arvalid && arready)
      araddr_q <= araddr;

  // Read data loaded once and frozen while rready is low
  always_ff @(posedge clk_main_a0)
    if (rd_state == ocl_bus_pkg::rd_decode)
      rdata <= rd_value;

endmodule

//--- source/ocl_write_channel.sv
`timescale 1ns/10ps

module ocl_write_channel
(
  input  logic                           clk_main_a0,
  input  logic                           rst_main_n_sync,
  // Write address
  input  logic                           awvalid,
  input  logic [ocl_bus_pkg::addr_w-1:0] awaddr,
  output logic                           awready,
  // Write data
  input  logic                           wvalid,
  input  logic [ocl_bus_pkg::data_w-1:0] wdata,
  output logic                           wready,
  // Write response
  output logic                           bvalid,
  output logic [1:0]                     bresp,
  input  logic                           bready,
  // Register write strobe
  output logic                           reg_wr,
  output logic [ocl_bus_pkg::addr_w-1:0] reg_wr_addr,
  output logic [ocl_bus_pkg::data_w-1:0] reg_wr_data
);

  ocl_bus_pkg::wr_state_t wr_state;
  ocl_bus_pkg::wr_state_t wr_state_nxt;

  // Address held between AW and W transfers
  logic [ocl_bus_pkg::addr_w-1:0] wr_addr_q;

  // ----------------------------------------------------------------------
  // Handshake decode
  // ----------------------------------------------------------------------
  // New address only when idle
  assign awready = (wr_state == ocl_bus_pkg::wr_idle);

  // Data accepted as soon as it shows up
  assign wready  = (wr_state == ocl_bus_pkg::wr_data) && wvalid;

  // Response pending until the master takes it
  assign bvalid  = (wr_state == ocl_bus_pkg::wr_resp);
  assign bresp   = ocl_bus_pkg::resp_okay;

  // One strobe per write on the W transfer edge
  assign reg_wr      = wready;
  assign reg_wr_addr = wr_addr_q;
  assign reg_wr_data = wdata;

  // ----------------------------------------------------------------------
  // State machine
  // ----------------------------------------------------------------------
  always_comb
  begin
    wr_state_nxt = wr_state;
    case (wr_state)
      ocl_bus_pkg::wr_idle:
        if (awvalid)
          wr_state_nxt = ocl_bus_pkg::wr_data;
      ocl_bus_pkg::wr_data:
        if (wvalid)
          wr_state_nxt = ocl_bus_pkg::wr_resp;
      ocl_bus_pkg::wr_resp:
        // Stays here under back-pressure
        if (bready)
          wr_state_nxt = ocl_bus_pkg::wr_idle;
      default:
        wr_state_nxt = ocl_bus_pkg::wr_idle;
    endcase
  end

  always_ff @(posedge clk_main_a0)
    if (!rst_main_n_sync)
      wr_state <= ocl_bus_pkg::wr_idle;
    else
      wr_state <= wr_state_nxt;

  // Latch on the AW transfer
  always_ff @(posedge clk_main_a0)
    if (awvalid && awready)
      wr_addr_q <= awaddr;

endmodule

//--- source/vled_status.sv
`timescale 1ns/10ps

module vled_status
(
  input  logic                             clk_main_a0,
  input  logic                             rst_main_n_sync,
  input  logic [hello_reg_pkg::vled_w-1:0] status_vdip,
  input  logic [hello_reg_pkg::vled_w-1:0] vled_value,
  output logic [hello_reg_pkg::vled_w-1:0] status_vled
);

  // Two stage DIP synchronizer
  logic [hello_reg_pkg::vled_w-1:0] vdip_q;
  logic [hello_reg_pkg::vled_w-1:0] vdip_q2;

  // LED lanes gated by the switches
  logic [hello_reg_pkg::vled_w-1:0] vled_masked;

  // ----------------------------------------------------------------------
  // DIP input sync
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_main_a0)
    if (!rst_main_n_sync)
    begin
      vdip_q  <= '0;
      vdip_q2 <= '0;
    end
    else
    begin
      vdip_q  <= status_vdip;
      vdip_q2 <= vdip_q;
    end

  // ----------------------------------------------------------------------
  // Masked LED output
  // ----------------------------------------------------------------------
  // A switch that is off darkens its LED
  assign vled_masked = vled_value & vdip_q2;

  // Output flop one cycle behind vled_value
  always_ff @(posedge clk_main_a0)
    if (!rst_main_n_sync)
      status_vled <= '0;
    else
      status_vled <= vled_masked;

endmodule

//--- test/hello_regs_assertions.sv
`timescale 1ns/10ps

module hello_regs_assertions
(
  input logic                           clk_main_a0,
  input logic                           rst_main_n_sync,
  // Address side of the channel
  input logic                           addr_valid,
  input logic                           addr_ready,
  // Response side of the channel
  input logic                           rsp_valid,
  input logic                           rsp_ready,
  input logic                           data_check_en,
  input logic [ocl_bus_pkg::data_w-1:0] rsp_data
);

  // ----------------------------------------------------------------------
  // Response handshake rules
  // ----------------------------------------------------------------------
  // Valid may only drop after the ready transfer
  valid_hold_a : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rsp_valid && !rsp_ready |=> rsp_valid)
    else $error("response valid dropped before ready");

  // Payload frozen while stalled
  data_stable_a : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    data_check_en && rsp_valid && !rsp_ready |=> $stable(rsp_data))
    else $error("response data changed while stalled");

  // ----------------------------------------------------------------------
  // Address blocking while a transfer is pending
  // ----------------------------------------------------------------------
  // Taken address closes the address channel
  addr_taken_a : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    addr_valid && addr_ready |=> !addr_ready)
    else $error("address ready still high after an address transfer");

  // Stays closed until the response transfer
  addr_held_a : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    !addr_ready && !(rsp_valid && rsp_ready) |=> !addr_ready)
    else $error("address ready rose before the response transfer");

endmodule

// Write response carries no data
bind ocl_write_channel hello_regs_assertions wr_chk_i
(
  .clk_main_a0     (clk_main_a0),
  .rst_main_n_sync (rst_main_n_sync),
  .addr_valid      (awvalid),
  .addr_ready      (awready),
  .rsp_valid       (bvalid),
  .rsp_ready       (bready),
  .data_check_en   (1'b0),
  .rsp_data        ('0)
);

bind ocl_read_channel hello_regs_assertions rd_chk_i
(
  .clk_main_a0     (clk_main_a0),
  .rst_main_n_sync (rst_main_n_sync),
  .addr_valid      (arvalid),
  .addr_ready      (arready),
  .rsp_valid       (rvalid),
  .rsp_ready       (rready),
  .data_check_en   (1'b1),
  .rsp_data        (rdata)
);

//--- test/hello_regs_testdata.txt
# op     addr/dip  data/expected
# write: data written; read: expected rdata; dip: expected status_vled
dip      0000ffff  00000000
read     00000500  00000000
read     00000504  00000000
write    00000500  12345678
read     00000500  78563412
read     00000504  00005678
dip      0000ffff  00005678
dip      00000f0f  00000608
dip      000000f0  00000070
write    00000508  deadbeef
read     00000500  78563412
read     00000504  00005678
read     00000508  00000000
read     00000000  00000000
write    00000500  a5c3e10f
read     00000500  0fe1c3a5
read     00000504  0000e10f
dip      0000ff00  0000e100
write    00000504  ffffffff
read     00000504  0000e10f

//--- test/tb_hello_regs.sv
`timescale 1ns/10ps

module tb_hello_regs;

  localparam int clk_period = 8;

  logic        clk_main_a0;
  logic        rst_main_n_sync;
  logic        awvalid, wvalid, bready, arvalid, rready;
  logic [31:0] awaddr, araddr, wdata, rdata;
  logic        awready, wready, bvalid, arready, rvalid;
  logic [1:0]  bresp, rresp;
  logic [15:0] status_vdip, status_vled;

  // Operation table from the data file (0 write, 1 read, 2 dip)
  int          op_kind[$];
  logic [31:0] op_addr[$];
  logic [31:0] op_value[$];
  bit          ops_loaded;
  int          error_count;
  integer      seed;

  hello_regs_top dut_i
  (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .status_vdip     (status_vdip),
    .status_vled     (status_vled)
  );

  always #(clk_period / 2) clk_main_a0 = ~clk_main_a0;

  // Register name for messages
  function automatic string reg_name(input logic [31:0] addr);
    if (addr == hello_reg_pkg::hello_world_addr)
      return "hello";
    else if (addr == hello_reg_pkg::vled_addr)
      return "vled";
    return "unmapped";
  endfunction

  // ----------------------------------------------------------------------
  // Data file
  // ----------------------------------------------------------------------
  task automatic load_ops();
    integer           fd;
    integer           fields;
    logic [8*80-1:0]  line;
    logic [8*8-1:0]   op;
    logic [31:0]      a;
    logic [31:0]      v;
    fd = $fopen("test/hello_regs_testdata.txt", "r");
    if (fd == 0)
    begin
      error_count++;
      $display("could not open the test data file");
      return;
    end
    while ($fgets(line, fd) != 0)
    begin
      fields = $sscanf(line, "%s %h %h", op, a, v);
      // Comment and blank lines skipped
      if (fields != 3 || op == "#")
        continue;
      if (op == "write")
        op_kind.push_back(0);
      else if (op == "read")
        op_kind.push_back(1);
      else if (op == "dip")
        op_kind.push_back(2);
      else
      begin
        error_count++;
        $display("unknown operation in the test data file");
        continue;
      end
      op_addr.push_back(a);
      op_value.push_back(v);
    end
    $fclose(fd);
    if (op_kind.size() == 0)
    begin
      error_count++;
      $display("the test data file holds no operations");
    end
  endtask

  // ----------------------------------------------------------------------
  // Bus tasks enter and leave 1 ns after a rising edge
  // ----------------------------------------------------------------------
  task automatic do_write(input logic [31:0] addr, input logic [31:0] data);
    int unsigned stall;
    stall = $unsigned($random(seed)) % 4;
    awvalid = 1'b1;
    awaddr  = addr;
    do @(negedge clk_main_a0); while (!awready);
    @(posedge clk_main_a0);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b1;
    wdata   = data;
    do @(negedge clk_main_a0); while (!wready);
    @(posedge clk_main_a0);
    #1;
    wvalid = 1'b0;
    // Back-pressure on the response
    repeat (stall)
    begin
      @(posedge clk_main_a0);
      #1;
    end
    bready = 1'b1;
    do @(negedge clk_main_a0); while (!bvalid);
    assert (bresp == 2'b00)
    else
    begin
      error_count++;
      $display("mismatch at %0t: write to %s 0x%08h got bresp %b", $time, reg_name(addr),
               addr, bresp);
    end
    @(posedge clk_main_a0);
    #1;
    bready = 1'b0;
  endtask

  task automatic do_read(input logic [31:0] addr, input logic [31:0] expected);
    int unsigned stall;
    stall   = $unsigned($random(seed)) % 4;
    arvalid = 1'b1;
    araddr  = addr;
    do @(negedge clk_main_a0); while (!arready);
    @(posedge clk_main_a0);
    #1;
    arvalid = 1'b0;
    repeat (stall)
    begin
      @(posedge clk_main_a0);
      #1;
    end
    rready = 1'b1;
    do @(negedge clk_main_a0); while (!rvalid);
    assert (rdata == expected && rresp == 2'b00)
    else
    begin
      error_count++;
      $display("mismatch at %0t: read of %s 0x%08h gave 0x%08h resp %b, expected 0x%08h",
               $time, reg_name(addr), addr, rdata, rresp, expected);
    end
    @(posedge clk_main_a0);
    #1;
    rready = 1'b0;
  endtask

  // Sync path takes three cycles so five is plenty
  task automatic do_dip(input logic [15:0] dip, input logic [15:0] expected);
    status_vdip = dip;
    repeat (5) @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    assert (status_vled == expected)
    else
    begin
      error_count++;
      $display("mismatch at %0t: dip 0x%04h gave status_vled 0x%04h, expected 0x%04h",
               $time, dip, status_vled, expected);
    end
    @(posedge clk_main_a0);
    #1;
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial
  begin
    clk_main_a0     = 1'b0;
    rst_main_n_sync = 1'b0;
    {awvalid, wvalid, bready, arvalid, rready} = '0;
    awaddr      = '0;
    araddr      = '0;
    wdata       = '0;
    status_vdip = '0;
    seed        = 25;
    error_count = 0;
    load_ops();
    ops_loaded = 1'b1;
    repeat (16) @(posedge clk_main_a0);
    #1;
    rst_main_n_sync = 1'b1;
    @(posedge clk_main_a0);
    #1;
    for (int i = 0; i < op_kind.size(); i++)
      case (op_kind[i])
        0: do_write(op_addr[i], op_value[i]);
        1: do_read(op_addr[i], op_value[i]);
        default: do_dip(op_addr[i][15:0], op_value[i][15:0]);
      endcase
    $display("errors: %0d", error_count);
    if (error_count == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // Watchdog allows 40 cycles per operation plus reset
  initial
  begin
    wait (ops_loaded);
    #((op_kind.size() + 1) * 40 * clk_period);
    $display("timeout, the run did not finish in time");
    $display("sim failed");
    $finish;
  end

endmodule

//--- vlog.f
source/ocl_bus_pkg.sv
source/hello_reg_pkg.sv
source/ocl_write_channel.sv
source/ocl_read_channel.sv
source/hello_reg_bank.sv
source/vled_status.sv
source/hello_regs_top.sv
test/hello_regs_assertions.sv
test/tb_hello_regs.sv
